// File: run.sh
#!/bin/bash
# Build and run the testbench with Verilator, then scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_riscv_core \
    -Mdir obj_dir -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }
grep -q "Test failures found" sim.log && { echo "FAIL"; exit 1; } || echo "PASS"

// File: sources.f
src/riscv_pkg.sv
src/riscv_fetch.sv
src/riscv_decode.sv
src/riscv_regfile.sv
src/riscv_exec.sv
src/riscv_lsu.sv
src/riscv_core.sv
verif/riscv_checker.sv
verif/tb_riscv_core.sv

// File: src/riscv_core.sv
//----------------------------------------
// Top level of the in-order RV32I subset
// core with instruction and data ports
//----------------------------------------

`timescale 1ns/1ps

module riscv_core (
     input  logic                clk_i
    ,input  logic                rst_i
    ,input  logic                mem_i_valid_i
    ,input  riscv_pkg::word_t    mem_i_inst_i
    ,input  logic                mem_d_accept_i
    ,input  logic                mem_d_ack_i
    ,input  riscv_pkg::word_t    mem_d_data_rd_i
    ,output logic                mem_i_rd_o
    ,output riscv_pkg::word_t    mem_i_pc_o
    ,output riscv_pkg::word_t    mem_d_addr_o
    ,output riscv_pkg::word_t    mem_d_data_wr_o
    ,output logic                mem_d_rd_o
    ,output riscv_pkg::strobe_t  mem_d_wr_o
);

    riscv_pkg::word_t    instr_w;
    riscv_pkg::word_t    pc_w;
    logic                exec_valid_w;
    logic                branch_request_w;
    riscv_pkg::word_t    branch_pc_w;
    logic                lsu_stall_w;
    riscv_pkg::reg_idx_t rd_idx_w;
    riscv_pkg::reg_idx_t ra_idx_w;
    riscv_pkg::reg_idx_t rb_idx_w;
    riscv_pkg::word_t    imm_w;
    riscv_pkg::alu_op_e  alu_op_w;
    logic                use_imm_w;
    logic                rd_valid_w;
    logic                is_load_w;
    logic                is_store_w;
    logic                is_branch_w;
    logic                branch_ne_w;
    riscv_pkg::word_t    ra_value_w;
    riscv_pkg::word_t    rb_value_w;
    logic                rf_wr_en_w;
    riscv_pkg::reg_idx_t rf_wr_idx_w;
    riscv_pkg::word_t    rf_wr_data_w;
    logic                lsu_wb_valid_w;
    riscv_pkg::word_t    lsu_wb_value_w;

    //----------------------------------------
    // Front end
    //----------------------------------------
    riscv_fetch u_fetch (
         .clk_i            (clk_i)
        ,.rst_i            (rst_i)
        ,.mem_valid_i      (mem_i_valid_i)
        ,.mem_inst_i       (mem_i_inst_i)
        ,.branch_request_i (branch_request_w)
        ,.branch_pc_i      (branch_pc_w)
        ,.stall_i          (lsu_stall_w)
        ,.mem_rd_o         (mem_i_rd_o)
        ,.mem_pc_o         (mem_i_pc_o)
        ,.instr_o          (instr_w)
        ,.pc_o             (pc_w)
        ,.exec_valid_o     (exec_valid_w)
    );

    riscv_decode u_decode (
         .instr_i     (instr_w)
        ,.rd_idx_o    (rd_idx_w)
        ,.ra_idx_o    (ra_idx_w)
        ,.rb_idx_o    (rb_idx_w)
        ,.imm_o       (imm_w)
        ,.alu_op_o    (alu_op_w)
        ,.use_imm_o   (use_imm_w)
        ,.rd_valid_o  (rd_valid_w)
        ,.is_load_o   (is_load_w)
        ,.is_store_o  (is_store_w)
        ,.is_branch_o (is_branch_w)
        ,.branch_ne_o (branch_ne_w)
    );

    riscv_regfile u_regfile (
         .clk_i      (clk_i)
        ,.rst_i      (rst_i)
        ,.ra_idx_i   (ra_idx_w)
        ,.rb_idx_i   (rb_idx_w)
        ,.wr_en_i    (rf_wr_en_w)
        ,.wr_idx_i   (rf_wr_idx_w)
        ,.wr_data_i  (rf_wr_data_w)
        ,.ra_value_o (ra_value_w)
        ,.rb_value_o (rb_value_w)
    );

    //----------------------------------------
    // Execute and memory access
    //----------------------------------------
    riscv_exec u_exec (
         .exec_valid_i     (exec_valid_w)
        ,.pc_i             (pc_w)
        ,.ra_value_i       (ra_value_w)
        ,.rb_value_i       (rb_value_w)
        ,.imm_i            (imm_w)
        ,.alu_op_i         (alu_op_w)
        ,.use_imm_i        (use_imm_w)
        ,.rd_idx_i         (rd_idx_w)
        ,.rd_valid_i       (rd_valid_w)
        ,.is_branch_i      (is_branch_w)
        ,.branch_ne_i      (branch_ne_w)
        ,.lsu_wb_valid_i   (lsu_wb_valid_w)
        ,.lsu_wb_value_i   (lsu_wb_value_w)
        ,.is_load_i        (is_load_w)
        ,.branch_request_o (branch_request_w)
        ,.branch_pc_o      (branch_pc_w)
        ,.rf_wr_en_o       (rf_wr_en_w)
        ,.rf_wr_idx_o      (rf_wr_idx_w)
        ,.rf_wr_data_o     (rf_wr_data_w)
    );

    riscv_lsu u_lsu (
         .clk_i         (clk_i)
        ,.rst_i         (rst_i)
        ,.exec_valid_i  (exec_valid_w)
        ,.is_load_i     (is_load_w)
        ,.is_store_i    (is_store_w)
        ,.ra_value_i    (ra_value_w)
        ,.rb_value_i    (rb_value_w)
        ,.imm_i         (imm_w)
        ,.mem_accept_i  (mem_d_accept_i)
        ,.mem_ack_i     (mem_d_ack_i)
        ,.mem_data_rd_i (mem_d_data_rd_i)
        ,.mem_addr_o    (mem_d_addr_o)
        ,.mem_data_wr_o (mem_d_data_wr_o)
        ,.mem_rd_o      (mem_d_rd_o)
        ,.mem_wr_o      (mem_d_wr_o)
        ,.stall_o       (lsu_stall_w)
        ,.wb_valid_o    (lsu_wb_valid_w)
        ,.wb_value_o    (lsu_wb_value_w)
    );

endmodule

// File: src/riscv_decode.sv
//----------------------------------------
// Instruction decoder for the RV32I subset
// Pure combinational, reads the held word
//----------------------------------------

`timescale 1ns/1ps

module riscv_decode (
     input  riscv_pkg::word_t    instr_i
    ,output riscv_pkg::reg_idx_t rd_idx_o
    ,output riscv_pkg::reg_idx_t ra_idx_o
    ,output riscv_pkg::reg_idx_t rb_idx_o
    ,output riscv_pkg::word_t    imm_o
    ,output riscv_pkg::alu_op_e  alu_op_o
    ,output logic                use_imm_o
    ,output logic                rd_valid_o
    ,output logic                is_load_o
    ,output logic                is_store_o
    ,output logic                is_branch_o
    ,output logic                branch_ne_o
);

    logic [6:0]       opcode_w;
    logic [2:0]       funct3_w;
    logic [6:0]       funct7_w;
    riscv_pkg::word_t imm_i_w;
    riscv_pkg::word_t imm_s_w;
    riscv_pkg::word_t imm_b_w;
    riscv_pkg::word_t imm_u_w;
    logic             writes_rd_w;

    assign opcode_w = instr_i[6:0];
    assign funct3_w = instr_i[14:12];
    assign funct7_w = instr_i[31:25];

    assign rd_idx_o = instr_i[11:7];
    assign ra_idx_o = instr_i[19:15];
    assign rb_idx_o = instr_i[24:20];

    // Sign extended immediate formats
    assign imm_i_w = {{20{instr_i[31]}}, instr_i[31:20]};
    assign imm_s_w = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign imm_b_w = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                      instr_i[30:25], instr_i[11:8], 1'b0};
    assign imm_u_w = {instr_i[31:12], 12'b0};

    always_comb begin
        alu_op_o    = riscv_pkg::ALU_ADD;
        imm_o       = imm_i_w;
        use_imm_o   = 1'b0;
        writes_rd_w = 1'b0;
        is_load_o   = 1'b0;
        is_store_o  = 1'b0;
        is_branch_o = 1'b0;
        branch_ne_o = 1'b0;

        case (opcode_w)
        riscv_pkg::OPC_LUI: begin
            writes_rd_w = 1'b1;
            use_imm_o   = 1'b1;
            imm_o       = imm_u_w;
            alu_op_o    = riscv_pkg::ALU_PASS_B;
        end
        riscv_pkg::OPC_OP_IMM: begin
            // ADDI only
            writes_rd_w = (funct3_w == 3'b000);
            use_imm_o   = 1'b1;
        end
        riscv_pkg::OPC_OP: begin
            writes_rd_w = 1'b1;
            case ({funct7_w, funct3_w})
            {7'h00, 3'b000}: alu_op_o = riscv_pkg::ALU_ADD;
            {7'h20, 3'b000}: alu_op_o = riscv_pkg::ALU_SUB;
            {7'h00, 3'b100}: alu_op_o = riscv_pkg::ALU_XOR;
            {7'h00, 3'b110}: alu_op_o = riscv_pkg::ALU_OR;
            {7'h00, 3'b111}: alu_op_o = riscv_pkg::ALU_AND;
            default:         writes_rd_w = 1'b0;
            endcase
        end
        riscv_pkg::OPC_LOAD: begin
            writes_rd_w = (funct3_w == 3'b010);
            is_load_o   = (funct3_w == 3'b010);
        end
        riscv_pkg::OPC_STORE: begin
            imm_o      = imm_s_w;
            is_store_o = (funct3_w == 3'b010);
        end
        riscv_pkg::OPC_BRANCH: begin
            // BEQ and BNE differ in funct3 bit 0
            imm_o       = imm_b_w;
            is_branch_o = (funct3_w[2:1] == 2'b00);
            branch_ne_o = funct3_w[0];
        end
        default: ;
        endcase
    end

    // Results aimed at x0 are discarded
    assign rd_valid_o = writes_rd_w && (rd_idx_o != 5'd0);

endmodule

// File: src/riscv_exec.sv
//----------------------------------------
// ALU, branch resolution and the single
// register file write port
//----------------------------------------

`timescale 1ns/1ps

module riscv_exec (
     input  logic                exec_valid_i
    ,input  riscv_pkg::word_t    pc_i
    ,input  riscv_pkg::word_t    ra_value_i
    ,input  riscv_pkg::word_t    rb_value_i
    ,input  riscv_pkg::word_t    imm_i
    ,input  riscv_pkg::alu_op_e  alu_op_i
    ,input  logic                use_imm_i
    ,input  riscv_pkg::reg_idx_t rd_idx_i
    ,input  logic                rd_valid_i
    ,input  logic                is_branch_i
    ,input  logic                branch_ne_i
    ,input  logic                lsu_wb_valid_i
    ,input  riscv_pkg::word_t    lsu_wb_value_i
    ,input  logic                is_load_i
    ,output logic                branch_request_o
    ,output riscv_pkg::word_t    branch_pc_o
    ,output logic                rf_wr_en_o
    ,output riscv_pkg::reg_idx_t rf_wr_idx_o
    ,output riscv_pkg::word_t    rf_wr_data_o
);

    riscv_pkg::word_t operand_b_w;
    riscv_pkg::word_t alu_result_w;
    logic             equal_w;

    assign operand_b_w = use_imm_i ? imm_i : rb_value_i;

    always_comb begin
        case (alu_op_i)
        riscv_pkg::ALU_SUB:    alu_result_w = ra_value_i - operand_b_w;
        riscv_pkg::ALU_AND:    alu_result_w = ra_value_i & operand_b_w;
        riscv_pkg::ALU_OR:     alu_result_w = ra_value_i | operand_b_w;
        riscv_pkg::ALU_XOR:    alu_result_w = ra_value_i ^ operand_b_w;
        riscv_pkg::ALU_PASS_B: alu_result_w = operand_b_w;
        default:               alu_result_w = ra_value_i + operand_b_w;
        endcase
    end

    // Branch compare on the register operands
    assign equal_w          = (ra_value_i == rb_value_i);
    assign branch_request_o = exec_valid_i && is_branch_i && (equal_w ^ branch_ne_i);
    assign branch_pc_o      = pc_i + imm_i;

    // ALU results in the exec cycle, loads when the ack returns
    assign rf_wr_en_o   = rd_valid_i && ((exec_valid_i && !is_load_i) ||
                                         (lsu_wb_valid_i && is_load_i));
    assign rf_wr_idx_o  = rd_idx_i;
    assign rf_wr_data_o = is_load_i ? lsu_wb_value_i : alu_result_w;

endmodule

// File: src/riscv_fetch.sv
//----------------------------------------
// Program counter, instruction register and
// the fetch / execute sequencing FSM
//----------------------------------------

`timescale 1ns/1ps

module riscv_fetch (
     input  logic                clk_i
    ,input  logic                rst_i
    ,input  logic                mem_valid_i
    ,input  riscv_pkg::word_t    mem_inst_i
    ,input  logic                branch_request_i
    ,input  riscv_pkg::word_t    branch_pc_i
    ,input  logic                stall_i
    ,output logic                mem_rd_o
    ,output riscv_pkg::word_t    mem_pc_o
    ,output riscv_pkg::word_t    instr_o
    ,output riscv_pkg::word_t    pc_o
    ,output logic                exec_valid_o
);

    riscv_pkg::fetch_state_e state_q;
    riscv_pkg::word_t        pc_q;
    riscv_pkg::word_t        instr_q;
    logic                    mem_rd_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q  <= riscv_pkg::ST_FETCH;
            mem_rd_q <= 1'b0;
            pc_q     <= riscv_pkg::RESET_VECTOR;
        end else begin
            case (state_q)
            riscv_pkg::ST_FETCH: begin
                // Idle only in the first cycle out of reset
                if (!mem_rd_q) begin
                    mem_rd_q <= 1'b1;
                end else if (mem_valid_i) begin
                    mem_rd_q <= 1'b0;
                    state_q  <= riscv_pkg::ST_EXEC;
                end
            end
            riscv_pkg::ST_EXEC: begin
                pc_q <= branch_request_i ? branch_pc_i : pc_q + riscv_pkg::INSTR_BYTES;
                if (stall_i) begin
                    state_q <= riscv_pkg::ST_MEM_WAIT;
                end else begin
                    state_q  <= riscv_pkg::ST_FETCH;
                    mem_rd_q <= 1'b1;
                end
            end
            riscv_pkg::ST_MEM_WAIT: begin
                if (!stall_i) begin
                    state_q  <= riscv_pkg::ST_FETCH;
                    mem_rd_q <= 1'b1;
                end
            end
            default: state_q <= riscv_pkg::ST_FETCH;
            endcase
        end
    end

    // Instruction word captured at the valid cycle
    always_ff @(posedge clk_i) begin
        if (state_q == riscv_pkg::ST_FETCH && mem_rd_q && mem_valid_i) begin
            instr_q <= mem_inst_i;
        end
    end

    assign mem_rd_o     = mem_rd_q;
    assign mem_pc_o     = pc_q;
    assign pc_o         = pc_q;
    assign instr_o      = instr_q;
    assign exec_valid_o = (state_q == riscv_pkg::ST_EXEC);

    // A pending fetch keeps its request and address
    a_fetch_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_rd_o && !mem_valid_i |=> mem_rd_o && $stable(mem_pc_o));

endmodule

// File: src/riscv_lsu.sv
//----------------------------------------
// Word load/store unit on the data port
// One request at a time, accept then ack
//----------------------------------------

`timescale 1ns/1ps

module riscv_lsu (
     input  logic                clk_i
    ,input  logic                rst_i
    ,input  logic                exec_valid_i
    ,input  logic                is_load_i
    ,input  logic                is_store_i
    ,input  riscv_pkg::word_t    ra_value_i
    ,input  riscv_pkg::word_t    rb_value_i
    ,input  riscv_pkg::word_t    imm_i
    ,input  logic                mem_accept_i
    ,input  logic                mem_ack_i
    ,input  riscv_pkg::word_t    mem_data_rd_i
    ,output riscv_pkg::word_t    mem_addr_o
    ,output riscv_pkg::word_t    mem_data_wr_o
    ,output logic                mem_rd_o
    ,output riscv_pkg::strobe_t  mem_wr_o
    ,output logic                stall_o
    ,output logic                wb_valid_o
    ,output riscv_pkg::word_t    wb_value_o
);

    riscv_pkg::lsu_state_e state_q;
    riscv_pkg::word_t      addr_q;
    riscv_pkg::word_t      data_q;
    logic                  load_q;
    logic                  start_w;

    assign start_w = exec_valid_i && (is_load_i || is_store_i);

    //----------------------------------------
    // Request sequencing
    //----------------------------------------
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= riscv_pkg::LSU_IDLE;
            load_q  <= 1'b0;
        end else begin
            case (state_q)
            riscv_pkg::LSU_IDLE: begin
                if (start_w) begin
                    state_q <= riscv_pkg::LSU_REQ;
                    load_q  <= is_load_i;
                end
            end
            riscv_pkg::LSU_REQ: begin
                // Ack may arrive with the accept
                if (mem_accept_i) begin
                    state_q <= mem_ack_i ? riscv_pkg::LSU_IDLE : riscv_pkg::LSU_ACK;
                end
            end
            riscv_pkg::LSU_ACK: begin
                if (mem_ack_i) begin
                    state_q <= riscv_pkg::LSU_IDLE;
                end
            end
            default: state_q <= riscv_pkg::LSU_IDLE;
            endcase
        end
    end

    // Address and store data captured in the exec cycle
    always_ff @(posedge clk_i) begin
        if (start_w) begin
            addr_q <= ra_value_i + imm_i;
            data_q <= rb_value_i;
        end
    end

    assign mem_addr_o    = addr_q;
    assign mem_data_wr_o = data_q;
    assign mem_rd_o      = (state_q == riscv_pkg::LSU_REQ) && load_q;
    assign mem_wr_o      = (state_q == riscv_pkg::LSU_REQ && !load_q) ?
                           riscv_pkg::STROBE_WORD : '0;

    // Held from the exec cycle, released by the ack
    assign stall_o    = start_w || (state_q != riscv_pkg::LSU_IDLE && !mem_ack_i);
    assign wb_valid_o = (state_q != riscv_pkg::LSU_IDLE) && mem_ack_i && load_q;
    assign wb_value_o = mem_data_rd_i;

    // An access starts as either a read or a write
    a_rd_wr_excl: assert property (@(posedge clk_i) disable iff (rst_i)
        start_w |-> !(is_load_i && is_store_i));

    a_no_idle_ack: assert property (@(posedge clk_i) disable iff (rst_i)
        mem_ack_i |-> state_q != riscv_pkg::LSU_IDLE);

endmodule

// File: src/riscv_pkg.sv
//----------------------------------------
// Shared widths, types and encodings of
// the RV32I subset core
//----------------------------------------

package riscv_pkg;

    // Plain vector types
    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [3:0]  strobe_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        ST_FETCH,
        ST_EXEC,
        ST_MEM_WAIT
    } fetch_state_e;

    typedef enum logic [1:0] {
        LSU_IDLE,
        LSU_REQ,
        LSU_ACK
    } lsu_state_e;

    // Boot address and PC step
    localparam word_t RESET_VECTOR = 32'h8000_0000;
    localparam word_t INSTR_BYTES  = 32'd4;

    // Major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam strobe_t STROBE_WORD = 4'b1111;

endpackage

// File: src/riscv_regfile.sv
//----------------------------------------
// Register file, two async reads, one
// sync write, x0 hardwired to zero
//----------------------------------------

`timescale 1ns/1ps

module riscv_regfile (
     input  logic                clk_i
    ,input  logic                rst_i
    ,input  riscv_pkg::reg_idx_t ra_idx_i
    ,input  riscv_pkg::reg_idx_t rb_idx_i
    ,input  logic                wr_en_i
    ,input  riscv_pkg::reg_idx_t wr_idx_i
    ,input  riscv_pkg::word_t    wr_data_i
    ,output riscv_pkg::word_t    ra_value_o
    ,output riscv_pkg::word_t    rb_value_o
);

    riscv_pkg::word_t regs_q [1:31];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en_i && wr_idx_i != 5'd0) begin
            regs_q[wr_idx_i] <= wr_data_i;
        end
    end

    assign ra_value_o = (ra_idx_i == 5'd0) ? '0 : regs_q[ra_idx_i];
    assign rb_value_o = (rb_idx_i == 5'd0) ? '0 : regs_q[rb_idx_i];

endmodule

// File: verif/riscv_checker.sv
//----------------------------------------
// Instruction-set model of the core that
// watches both memory ports and compares
//----------------------------------------

`timescale 1ns/1ps

module riscv_checker (
     input  logic                clk_i
    ,input  logic                rst_i
    ,input  logic                mem_i_rd_o
    ,input  riscv_pkg::word_t    mem_i_pc_o
    ,input  logic                mem_i_valid_i
    ,input  riscv_pkg::word_t    mem_i_inst_i
    ,input  riscv_pkg::word_t    mem_d_addr_o
    ,input  riscv_pkg::word_t    mem_d_data_wr_o
    ,input  logic                mem_d_rd_o
    ,input  riscv_pkg::strobe_t  mem_d_wr_o
    ,input  logic                mem_d_accept_i
    ,input  logic                mem_d_ack_i
    ,input  riscv_pkg::word_t    data_init_i [0:63]
    ,output int                  error_count_o
);

    riscv_pkg::word_t regs [0:31];
    riscv_pkg::word_t dmem [0:63];
    riscv_pkg::word_t pc;
    bit               exp_store_q [$];
    riscv_pkg::word_t exp_addr_q [$];
    riscv_pkg::word_t exp_data_q [$];
    logic             outstanding;
    logic             rst_d;
    int               errors = 0;

    assign error_count_o = errors;

    task automatic check_value(input string name, input riscv_pkg::word_t exp_v,
                               input riscv_pkg::word_t act_v);
        if (exp_v !== act_v) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp_v, act_v);
        end
    endtask

    task automatic report(input string what);
        errors++;
        $display("%s at time %0t", what, $time);
    endtask

    //----------------------------------------
    // Architectural model, one step per fetch
    //----------------------------------------
    task automatic step_model(input riscv_pkg::word_t inst);
        logic [6:0]       opcode;
        logic [2:0]       f3;
        logic [6:0]       f7;
        logic [4:0]       rd;
        riscv_pkg::word_t a;
        riscv_pkg::word_t b;
        riscv_pkg::word_t imm_i;
        riscv_pkg::word_t imm_s;
        riscv_pkg::word_t imm_b;
        riscv_pkg::word_t addr;
        riscv_pkg::word_t res;
        riscv_pkg::word_t next_pc;
        logic             wr;

        opcode  = inst[6:0];
        f3      = inst[14:12];
        f7      = inst[31:25];
        rd      = inst[11:7];
        a       = regs[inst[19:15]];
        b       = regs[inst[24:20]];
        imm_i   = {{20{inst[31]}}, inst[31:20]};
        imm_s   = {{20{inst[31]}}, inst[31:25], inst[11:7]};
        imm_b   = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
        next_pc = pc + 32'd4;
        wr      = 1'b0;
        res     = '0;
        case (opcode)
        7'h37: begin
            res = {inst[31:12], 12'h000};
            wr  = 1'b1;
        end
        7'h13: begin
            wr  = (f3 == 3'd0);
            res = a + imm_i;
        end
        7'h33: begin
            wr = 1'b1;
            case ({f7, f3})
            {7'h00, 3'd0}: res = a + b;
            {7'h20, 3'd0}: res = a - b;
            {7'h00, 3'd4}: res = a ^ b;
            {7'h00, 3'd6}: res = a | b;
            {7'h00, 3'd7}: res = a & b;
            default:       wr = 1'b0;
            endcase
        end
        7'h03: begin
            if (f3 == 3'd2) begin
                addr = a + imm_i;
                res  = dmem[addr[7:2]];
                wr   = 1'b1;
                exp_store_q.push_back(1'b0);
                exp_addr_q.push_back(addr);
                exp_data_q.push_back('0);
            end
        end
        7'h23: begin
            if (f3 == 3'd2) begin
                addr = a + imm_s;
                dmem[addr[7:2]] = b;
                exp_store_q.push_back(1'b1);
                exp_addr_q.push_back(addr);
                exp_data_q.push_back(b);
            end
        end
        7'h63: begin
            // BEQ, or BNE with funct3 bit 0 set
            if (f3[2:1] == 2'b00 && ((a == b) != f3[0])) begin
                next_pc = pc + imm_b;
            end
        end
        default: ;
        endcase
        if (wr && rd != 5'd0) begin
            regs[rd] = res;
        end
        pc = next_pc;
    endtask

    always @(posedge clk_i) begin
        if ((rst_i || rst_d) && (mem_i_rd_o || mem_d_rd_o || mem_d_wr_o != '0)) begin
            report("memory request raised during or right after reset");
        end
        if (rst_i) begin
            pc = riscv_pkg::RESET_VECTOR;
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                dmem[i] = data_init_i[i];
            end
            exp_store_q.delete();
            exp_addr_q.delete();
            exp_data_q.delete();
            outstanding = 1'b0;
        end else begin
            if (mem_i_rd_o && mem_i_valid_i) begin
                check_value("fetch_pc", pc, mem_i_pc_o);
                // Previous load or store must be done by now
                if (exp_addr_q.size() != 0) begin
                    report("data request of the previous instruction was never made");
                    exp_store_q.delete();
                    exp_addr_q.delete();
                    exp_data_q.delete();
                end
                step_model(mem_i_inst_i);
            end
            if ((mem_d_rd_o || mem_d_wr_o != '0) && mem_d_accept_i) begin
                if (outstanding) begin
                    report("data request accepted while another is outstanding");
                end
                if (exp_addr_q.size() == 0) begin
                    report("data request that the program does not make");
                end else begin
                    check_value("data_is_store", {31'd0, exp_store_q[0]},
                                {31'd0, mem_d_wr_o != '0});
                    check_value("data_addr", exp_addr_q[0], mem_d_addr_o);
                    if (exp_store_q[0]) begin
                        check_value("store_data", exp_data_q[0], mem_d_data_wr_o);
                        check_value("store_strobe", {28'd0, riscv_pkg::STROBE_WORD},
                                    {28'd0, mem_d_wr_o});
                    end
                    void'(exp_store_q.pop_front());
                    void'(exp_addr_q.pop_front());
                    void'(exp_data_q.pop_front());
                end
                outstanding = 1'b1;
            end
            if (mem_d_ack_i) begin
                if (!outstanding) begin
                    report("data ack with no accepted request");
                end
                outstanding = 1'b0;
            end
        end
        rst_d <= rst_i;
    end

endmodule

// File: verif/tb_riscv_core.sv
//----------------------------------------
// Testbench, random program and memories
// with random delays, checked by a model
//----------------------------------------

`timescale 1ns/1ps

module tb_riscv_core;

    localparam int TIMEOUT_CYCLES = 20000;

    logic               clk_i = 1'b0;
    logic               rst_i;
    logic               mem_i_valid_i;
    riscv_pkg::word_t   mem_i_inst_i;
    logic               mem_d_accept_i;
    logic               mem_d_ack_i;
    riscv_pkg::word_t   mem_d_data_rd_i;
    logic               mem_i_rd_o;
    riscv_pkg::word_t   mem_i_pc_o;
    riscv_pkg::word_t   mem_d_addr_o;
    riscv_pkg::word_t   mem_d_data_wr_o;
    logic               mem_d_rd_o;
    riscv_pkg::strobe_t mem_d_wr_o;

    riscv_pkg::word_t prog [0:63];
    riscv_pkg::word_t data_init [0:63];
    riscv_pkg::word_t dmem [0:63];
    logic [31:0]      lfsr_q;
    int               check_errors;
    int               timeouts;
    int               i_wait;
    logic             i_busy;
    int               d_wait;
    int               d_phase;
    riscv_pkg::word_t d_rdata;

    always #20 clk_i = ~clk_i;

    riscv_core DUT (.*);

    riscv_checker u_checker (
         .clk_i(clk_i), .rst_i(rst_i), .mem_i_rd_o(mem_i_rd_o), .mem_i_pc_o(mem_i_pc_o)
        ,.mem_i_valid_i(mem_i_valid_i), .mem_i_inst_i(mem_i_inst_i)
        ,.mem_d_addr_o(mem_d_addr_o), .mem_d_data_wr_o(mem_d_data_wr_o)
        ,.mem_d_rd_o(mem_d_rd_o), .mem_d_wr_o(mem_d_wr_o)
        ,.mem_d_accept_i(mem_d_accept_i), .mem_d_ack_i(mem_d_ack_i)
        ,.data_init_i(data_init), .error_count_o(check_errors)
    );

    // Galois LFSR, one step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic build_program();
        logic [31:0] kind;
        logic [31:0] rd;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] imm;
        logic [31:0] sel;
        logic [31:0] off;

        for (int i = 0; i < 64; i++) begin
            take_bits(4, kind);
            take_bits(3, rd);
            take_bits(3, rs1);
            take_bits(3, rs2);
            take_bits(20, imm);
            take_bits(3, sel);
            take_bits(6, off);
            off = off << 2;
            case (kind)
            0, 1: prog[i] = {imm[19:0], rd[4:0], riscv_pkg::OPC_LUI};
            5, 6, 7: begin
                case (sel)
                1, 6:    prog[i] = {7'h20, rs2[4:0], rs1[4:0], 3'd0, rd[4:0], 7'h33};
                2, 7:    prog[i] = {7'h00, rs2[4:0], rs1[4:0], 3'd7, rd[4:0], 7'h33};
                3:       prog[i] = {7'h00, rs2[4:0], rs1[4:0], 3'd6, rd[4:0], 7'h33};
                4:       prog[i] = {7'h00, rs2[4:0], rs1[4:0], 3'd4, rd[4:0], 7'h33};
                default: prog[i] = {7'h00, rs2[4:0], rs1[4:0], 3'd0, rd[4:0], 7'h33};
                endcase
            end
            8, 9:   prog[i] = {off[11:0], 5'd0, 3'd2, rd[4:0], riscv_pkg::OPC_LOAD};
            10, 11: prog[i] = {off[11:5], rs2[4:0], 5'd0, 3'd2, off[4:0],
                               riscv_pkg::OPC_STORE};
            // Forward by 8, offset bits 4:1 are 4'b0100
            12, 13: prog[i] = {7'd0, rs2[4:0], rs1[4:0], 2'b00, sel[0], 4'b0100, 1'b0,
                               riscv_pkg::OPC_BRANCH};
            14:     prog[i] = {imm[19:0], rd[4:0], 7'h7f};
            default: prog[i] = {imm[11:0], rs1[4:0], 3'd0, rd[4:0], riscv_pkg::OPC_OP_IMM};
            endcase
        end
        for (int i = 0; i < 64; i++) begin
            take_bits(32, data_init[i]);
            dmem[i] = data_init[i];
        end
    endtask

    function automatic riscv_pkg::word_t inst_at(input riscv_pkg::word_t pc);
        riscv_pkg::word_t offset;
        offset = pc - riscv_pkg::RESET_VECTOR;
        if (offset < 32'd256) begin
            return prog[offset[7:2]];
        end
        return 32'h0000_0013;
    endfunction

    //----------------------------------------
    // Instruction memory, 0 to 3 cycle delay
    //----------------------------------------
    always @(negedge clk_i) begin
        logic [31:0] r;
        if (rst_i) begin
            mem_i_valid_i <= 1'b0;
            i_busy = 1'b0;
        end else if (mem_i_valid_i) begin
            mem_i_valid_i <= 1'b0;
        end else if (mem_i_rd_o) begin
            if (!i_busy) begin
                take_bits(2, r);
                i_wait = int'(r);
                i_busy = 1'b1;
            end
            if (i_wait == 0) begin
                mem_i_valid_i <= 1'b1;
                mem_i_inst_i  <= inst_at(mem_i_pc_o);
                i_busy = 1'b0;
            end else begin
                i_wait--;
            end
        end
    end

    // Data memory, random accept and ack delays
    always @(negedge clk_i) begin
        logic [31:0] r;
        mem_d_accept_i <= 1'b0;
        mem_d_ack_i    <= 1'b0;
        if (rst_i) begin
            d_phase = 0;
        end else begin
            if (d_phase == 0 && (mem_d_rd_o || mem_d_wr_o != '0)) begin
                take_bits(2, r);
                d_wait  = int'(r);
                d_phase = 1;
            end
            if (d_phase == 1) begin
                if (d_wait == 0) begin
                    mem_d_accept_i <= 1'b1;
                    d_rdata = dmem[mem_d_addr_o[7:2]];
                    if (mem_d_wr_o != '0) begin
                        dmem[mem_d_addr_o[7:2]] = mem_d_data_wr_o;
                    end
                    take_bits(2, r);
                    d_wait  = int'(r);
                    d_phase = 2;
                end else begin
                    d_wait--;
                end
            end else if (d_phase == 2) begin
                d_wait = (d_wait > 0) ? d_wait - 1 : 0;
            end
            if (d_phase == 2 && d_wait == 0) begin
                mem_d_ack_i     <= 1'b1;
                mem_d_data_rd_i <= d_rdata;
                d_phase = 0;
            end
        end
    end

    initial begin
        logic done;
        rst_i           = 1'b1;
        mem_i_valid_i   = 1'b0;
        mem_i_inst_i    = '0;
        mem_d_accept_i  = 1'b0;
        mem_d_ack_i     = 1'b0;
        mem_d_data_rd_i = '0;
        lfsr_q          = 32'hd9f6988f;
        timeouts        = 0;
        done            = 1'b0;
        build_program();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_i = 1'b0;

        // Run until the fetch past the program is answered
        for (int cycle = 0; cycle < TIMEOUT_CYCLES && !done; cycle++) begin
            @(negedge clk_i);
            if (mem_i_valid_i && mem_i_pc_o - riscv_pkg::RESET_VECTOR >= 32'd256) begin
                done = 1'b1;
            end
        end
        if (!done) begin
            timeouts++;
            $display("Timed out waiting for the fetch past the program end");
        end
        $display("Closing count: %0d check errors, %0d timeouts", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule
